/* memphy_pkg.sv */
// Read path shared definitions
`default_nettype none

package memphy_pkg;

	// AFI read data word
	localparam int AFI_DATA_WIDTH = 32;

	// Calibrated read latency, in AFI clock cycles
	localparam int RD_LAT_WIDTH = 5;
	localparam int MIN_READ_LATENCY = 2;

	// Status port widths
	localparam int CSR_ADDR_WIDTH = 2;
	localparam int CSR_DATA_WIDTH = 32;

	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;
	typedef logic [RD_LAT_WIDTH-1:0] rd_lat_t;
	typedef logic [CSR_ADDR_WIDTH-1:0] csr_addr_t;
	typedef logic [CSR_DATA_WIDTH-1:0] csr_data_t;

	// Register map
	// STATUS     pll_locked, cal_success, cal_fail in bits 2:0
	// DEBUG      stage, substage and group bytes of the debug info
	// READ_COUNT completed reads, 16 bits, wrapping
	// ERRORS     sticky overflow (bit 0) and underflow (bit 1), write 1 to clear
	localparam csr_addr_t CSR_ADDR_STATUS = 2'd0;
	localparam csr_addr_t CSR_ADDR_DEBUG = 2'd1;
	localparam csr_addr_t CSR_ADDR_READ_COUNT = 2'd2;
	localparam csr_addr_t CSR_ADDR_ERRORS = 2'd3;

endpackage

`default_nettype wire

/* read_valid_predictor.sv */
// Read valid predictor
`default_nettype none

module read_valid_predictor
	import memphy_pkg::*;
#(
	parameter int MAX_READ_LATENCY = 31
)
(
	input  wire     pll_afi_clk,
	input  wire     rst,
	input  wire     afi_rdata_en,
	input  rd_lat_t read_latency,
	output logic    pred_valid
);

	// One stage per cycle of latency; entry i is high i+1 edges after the enable
	logic [MAX_READ_LATENCY-1:0] en_sr;

	// Tap that the aligner samples exactly read_latency edges after the enable
	rd_lat_t tap;

	always_ff @(posedge pll_afi_clk)
	begin
		if (rst)
		begin
			en_sr <= '0;
		end
		else
		begin
			en_sr <= {en_sr[MAX_READ_LATENCY-2:0], afi_rdata_en};
		end
	end

	assign tap = read_latency - rd_lat_t'(1);

	// Out of range latency predicts nothing
	always_comb
	begin
		if (read_latency != '0 && int'(tap) < MAX_READ_LATENCY)
		begin
			pred_valid = en_sr[tap];
		end
		else
		begin
			pred_valid = 1'b0;
		end
	end

	// Calibration must keep the latency within the delay line while reading
	latency_in_range: assert property (
		@(posedge pll_afi_clk) disable iff (rst)
		afi_rdata_en |-> (int'(read_latency) >= MIN_READ_LATENCY &&
			int'(read_latency) <= MAX_READ_LATENCY)
	)
	else
		$error("read_latency %0d out of range with reads enabled", read_latency);

endmodule

`default_nettype wire

/* read_data_fifo.sv */
// Read data FIFO
`default_nettype none

module read_data_fifo
	import memphy_pkg::*;
#(
	parameter int FIFO_DEPTH = 16
)
(
	input  wire       pll_afi_clk,
	input  wire       rst,
	input  wire       mem_rdata_valid,
	input  afi_data_t mem_rdata,
	input  wire       fifo_pop,
	output afi_data_t fifo_rdata,
	output logic      fifo_empty,
	output logic      fifo_overflow
);

	localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	afi_data_t mem [FIFO_DEPTH];

	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [CNT_WIDTH-1:0] count;
	logic                 full;
	logic                 push_ok;
	logic                 pop_ok;

	// Pointer advance, also for depths that are not a power of two
	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(FIFO_DEPTH - 1))
			return '0;
		else
			return ptr + PTR_WIDTH'(1);
	endfunction

	assign full = (count == CNT_WIDTH'(FIFO_DEPTH));
	assign fifo_empty = (count == '0);

	// A push into a full buffer is lost
	assign push_ok = mem_rdata_valid && !full;
	assign pop_ok = fifo_pop && !fifo_empty;

	// Head word is visible as soon as it is written
	assign fifo_rdata = mem[rd_ptr];

	always_ff @(posedge pll_afi_clk)
	begin
		if (push_ok)
		begin
			mem[wr_ptr] <= mem_rdata;
		end
	end

	always_ff @(posedge pll_afi_clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			fifo_overflow <= 1'b0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop_ok)
				rd_ptr <= next_ptr(rd_ptr);
			// Simultaneous push and pop leave the fill level alone
			if (push_ok && !pop_ok)
				count <= count + CNT_WIDTH'(1);
			else if (pop_ok && !push_ok)
				count <= count - CNT_WIDTH'(1);
			fifo_overflow <= mem_rdata_valid && full;
		end
	end

	fill_in_range: assert property (
		@(posedge pll_afi_clk) disable iff (rst)
		int'(count) <= FIFO_DEPTH
	)
	else
		$error("FIFO fill count %0d above depth", count);

	// The aligner must never pop an empty buffer
	no_pop_when_empty: assert property (
		@(posedge pll_afi_clk) disable iff (rst)
		!(fifo_pop && fifo_empty)
	)
	else
		$error("pop issued on empty read FIFO");

endmodule

`default_nettype wire

/* read_data_aligner.sv */
// Read data aligner
`default_nettype none

module read_data_aligner
	import memphy_pkg::*;
(
	input  wire       pll_afi_clk,
	input  wire       rst,
	input  wire       pred_valid,
	input  afi_data_t fifo_rdata,
	input  wire       fifo_empty,
	output logic      fifo_pop,
	output afi_data_t afi_rdata,
	output logic      afi_rdata_valid,
	output logic      read_underflow
);

	// Predicted read that finds no captured word
	logic miss;

	// Pop only when the predictor expects data and the FIFO has some
	assign fifo_pop = pred_valid && !fifo_empty;
	assign miss = pred_valid && fifo_empty;

	// Read data word held between valids
	always_ff @(posedge pll_afi_clk)
	begin
		if (fifo_pop)
		begin
			afi_rdata <= fifo_rdata;
		end
	end

	always_ff @(posedge pll_afi_clk)
	begin
		if (rst)
		begin
			afi_rdata_valid <= 1'b0;
			read_underflow <= 1'b0;
		end
		else
		begin
			afi_rdata_valid <= fifo_pop;
			read_underflow <= miss;
		end
	end

	// A predicted read either delivers data or is reported missing
	valid_or_underflow: assert property (
		@(posedge pll_afi_clk) disable iff (rst)
		!(afi_rdata_valid && read_underflow)
	)
	else
		$error("afi_rdata_valid and read_underflow high together");

endmodule

`default_nettype wire

/* phy_status_csr.sv */
// PHY status registers
`default_nettype none

module phy_status_csr
	import memphy_pkg::*;
(
	input  wire         pll_afi_clk,
	input  wire         rst,
	input  wire         pll_locked,
	input  wire         afi_cal_success,
	input  wire         afi_cal_fail,
	input  wire  [23:0] afi_cal_debug_info,
	input  wire         afi_rdata_valid,
	input  wire         fifo_overflow,
	input  wire         read_underflow,
	input  csr_addr_t   csr_addr,
	input  wire         csr_read_req,
	input  wire         csr_write_req,
	input  csr_data_t   csr_wdata,
	output csr_data_t   csr_rdata,
	output logic        csr_rdata_valid
);

	localparam int READ_COUNT_WIDTH = 16;

	logic [READ_COUNT_WIDTH-1:0] read_count;
	logic                        err_overflow;
	logic                        err_underflow;
	logic                        err_clear;

	// Debug info fields from the sequencer
	logic [7:0] cal_fail_stage;
	logic [7:0] cal_fail_substage;
	logic [7:0] cal_fail_group;

	csr_data_t rd_mux;

	assign cal_fail_stage = afi_cal_debug_info[7:0];
	assign cal_fail_substage = afi_cal_debug_info[15:8];
	assign cal_fail_group = afi_cal_debug_info[23:16];

	assign err_clear = csr_write_req && (csr_addr == CSR_ADDR_ERRORS);

	// Completed reads, wraps at 16 bits
	always_ff @(posedge pll_afi_clk)
	begin
		if (rst)
			read_count <= '0;
		else if (afi_rdata_valid)
			read_count <= read_count + 1'b1;
	end

	// Sticky flags; a new event wins over a clear in the same cycle
	always_ff @(posedge pll_afi_clk)
	begin
		if (rst)
		begin
			err_overflow <= 1'b0;
			err_underflow <= 1'b0;
		end
		else
		begin
			err_overflow <= fifo_overflow || (err_overflow && !(err_clear && csr_wdata[0]));
			err_underflow <= read_underflow || (err_underflow && !(err_clear && csr_wdata[1]));
		end
	end

	always_comb
	begin
		rd_mux = '0;
		case (csr_addr)
			CSR_ADDR_STATUS:
				rd_mux[2:0] = {afi_cal_fail, afi_cal_success, pll_locked};
			CSR_ADDR_DEBUG:
				rd_mux[23:0] = {cal_fail_group, cal_fail_substage, cal_fail_stage};
			CSR_ADDR_READ_COUNT:
				rd_mux[READ_COUNT_WIDTH-1:0] = read_count;
			default:
				rd_mux[1:0] = {err_underflow, err_overflow};
		endcase
	end

	// Read data, one cycle after the request
	always_ff @(posedge pll_afi_clk)
	begin
		if (csr_read_req)
			csr_rdata <= rd_mux;
	end

	always_ff @(posedge pll_afi_clk)
	begin
		if (rst)
			csr_rdata_valid <= 1'b0;
		else
			csr_rdata_valid <= csr_read_req;
	end

endmodule

`default_nettype wire

/* memphy_read_top.sv */
// DDR3 PHY read path top level
`default_nettype none

module memphy_read_top
	import memphy_pkg::*;
#(
	parameter int FIFO_DEPTH = 16,
	parameter int MAX_READ_LATENCY = 31
)
(
	input  wire         pll_afi_clk,
	input  wire         rst,

	// Controller and sequencer
	input  wire         afi_rdata_en,
	input  rd_lat_t     read_latency,

	// Captured memory data, already in the AFI domain
	input  wire         mem_rdata_valid,
	input  afi_data_t   mem_rdata,

	output afi_data_t   afi_rdata,
	output logic        afi_rdata_valid,

	input  wire         pll_locked,
	input  wire         afi_cal_success,
	input  wire         afi_cal_fail,
	input  wire  [23:0] afi_cal_debug_info,

	input  csr_addr_t   csr_addr,
	input  wire         csr_read_req,
	input  wire         csr_write_req,
	input  csr_data_t   csr_wdata,
	output csr_data_t   csr_rdata,
	output logic        csr_rdata_valid
);

	logic      pred_valid;
	afi_data_t fifo_rdata;
	logic      fifo_empty;
	logic      fifo_pop;
	logic      fifo_overflow;
	logic      read_underflow;

	read_valid_predictor #(
		.MAX_READ_LATENCY(MAX_READ_LATENCY)
	) u_predictor (
		.pll_afi_clk  (pll_afi_clk),
		.rst          (rst),
		.afi_rdata_en (afi_rdata_en),
		.read_latency (read_latency),
		.pred_valid   (pred_valid)
	);

	read_data_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.pll_afi_clk     (pll_afi_clk),
		.rst             (rst),
		.mem_rdata_valid (mem_rdata_valid),
		.mem_rdata       (mem_rdata),
		.fifo_pop        (fifo_pop),
		.fifo_rdata      (fifo_rdata),
		.fifo_empty      (fifo_empty),
		.fifo_overflow   (fifo_overflow)
	);

	read_data_aligner u_aligner (
		.pll_afi_clk     (pll_afi_clk),
		.rst             (rst),
		.pred_valid      (pred_valid),
		.fifo_rdata      (fifo_rdata),
		.fifo_empty      (fifo_empty),
		.fifo_pop        (fifo_pop),
		.afi_rdata       (afi_rdata),
		.afi_rdata_valid (afi_rdata_valid),
		.read_underflow  (read_underflow)
	);

	// Status port sits beside the read path
	phy_status_csr u_csr (
		.pll_afi_clk        (pll_afi_clk),
		.rst                (rst),
		.pll_locked         (pll_locked),
		.afi_cal_success    (afi_cal_success),
		.afi_cal_fail       (afi_cal_fail),
		.afi_cal_debug_info (afi_cal_debug_info),
		.afi_rdata_valid    (afi_rdata_valid),
		.fifo_overflow      (fifo_overflow),
		.read_underflow     (read_underflow),
		.csr_addr           (csr_addr),
		.csr_read_req       (csr_read_req),
		.csr_write_req      (csr_write_req),
		.csr_wdata          (csr_wdata),
		.csr_rdata          (csr_rdata),
		.csr_rdata_valid    (csr_rdata_valid)
	);

endmodule

`default_nettype wire

/* tb_memphy.sv */
// Read path testbench
`default_nettype none

module tb_memphy
	import memphy_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 20;
	localparam int DRAIN_CYCLES = 34;
	localparam int CSR_TIMEOUT = 8;
	localparam int NUM_PHASES = 6;
	localparam int PHASE_CYCLES = 80;
	localparam int BURST_LEN = 24;

	logic        pll_afi_clk;
	logic        rst;
	logic        afi_rdata_en;
	rd_lat_t     read_latency;
	logic        mem_rdata_valid;
	afi_data_t   mem_rdata;
	afi_data_t   afi_rdata;
	logic        afi_rdata_valid;
	logic        pll_locked;
	logic        afi_cal_success;
	logic        afi_cal_fail;
	logic [23:0] afi_cal_debug_info;
	csr_addr_t   csr_addr;
	logic        csr_read_req;
	logic        csr_write_req;
	csr_data_t   csr_wdata;
	csr_data_t   csr_rdata;
	logic        csr_rdata_valid;

	// Reference model with words in push order and due edges keyed by edge number
	afi_data_t exp_q[$];
	bit        valid_due[int];
	bit        push_due[int];
	int        edge_n;
	int        lat;
	int        dly;
	int        valid_count;

	memphy_read_top dut0 (
		.pll_afi_clk        (pll_afi_clk),
		.rst                (rst),
		.afi_rdata_en       (afi_rdata_en),
		.read_latency       (read_latency),
		.mem_rdata_valid    (mem_rdata_valid),
		.mem_rdata          (mem_rdata),
		.afi_rdata          (afi_rdata),
		.afi_rdata_valid    (afi_rdata_valid),
		.pll_locked         (pll_locked),
		.afi_cal_success    (afi_cal_success),
		.afi_cal_fail       (afi_cal_fail),
		.afi_cal_debug_info (afi_cal_debug_info),
		.csr_addr           (csr_addr),
		.csr_read_req       (csr_read_req),
		.csr_write_req      (csr_write_req),
		.csr_wdata          (csr_wdata),
		.csr_rdata          (csr_rdata),
		.csr_rdata_valid    (csr_rdata_valid)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			fail_run($sformatf("mismatch at %0d ns: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	// One clock cycle, entered and left at a falling edge
	task automatic tick(input bit en, input bit withhold);
		bit        read_req;
		bit        want_valid;
		afi_data_t word;
		afi_rdata_en = en;
		// A withheld read gets neither data nor a valid
		if (en && !withhold)
		begin
			valid_due[edge_n + lat] = 1'b1;
			push_due[edge_n + dly] = 1'b1;
		end
		if (push_due.exists(edge_n))
		begin
			word = $urandom;
			mem_rdata_valid = 1'b1;
			mem_rdata = word;
			exp_q.push_back(word);
			push_due.delete(edge_n);
		end
		else
		begin
			mem_rdata_valid = 1'b0;
			mem_rdata = '0;
		end
		read_req = csr_read_req;
		@(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		want_valid = valid_due.exists(edge_n);
		check("afi_rdata_valid", 32'(afi_rdata_valid), 32'(want_valid));
		if (want_valid)
		begin
			check("afi_rdata", afi_rdata, exp_q.pop_front());
			valid_due.delete(edge_n);
			valid_count++;
		end
		check("csr_rdata_valid", 32'(csr_rdata_valid), 32'(read_req));
		edge_n++;
	endtask

	task automatic idle(input int n);
		repeat (n)
			tick(1'b0, 1'b0);
	endtask

	task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
		int tries;
		csr_addr = addr;
		csr_read_req = 1'b1;
		tick(1'b0, 1'b0);
		csr_read_req = 1'b0;
		tries = 0;
		while (!csr_rdata_valid)
		begin
			if (tries == CSR_TIMEOUT)
				fail_run("timeout waiting for csr_rdata_valid after a register read");
			tick(1'b0, 1'b0);
			tries++;
		end
		data = csr_rdata;
	endtask

	task automatic expect_csr(input csr_addr_t addr, input csr_data_t expected,
		input string name);
		csr_data_t data;
		csr_read(addr, data);
		check(name, data, expected);
	endtask

	task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
		csr_addr = addr;
		csr_wdata = data;
		csr_write_req = 1'b1;
		tick(1'b0, 1'b0);
		csr_write_req = 1'b0;
	endtask

	// Random latency and push offset; at most 15 words wait in the FIFO
	task automatic run_phase(input bit burst);
		bit en;
		lat = 2 + int'($urandom % 30);
		dly = lat - 1 - int'($urandom % ((lat < 15) ? lat : 15));
		read_latency = rd_lat_t'(lat);
		for (int i = 0; i < PHASE_CYCLES; i++)
		begin
			if (burst)
				en = (i < BURST_LEN);
			else
				en = (($urandom % 4) == 0);
			tick(en, 1'b0);
		end
		idle(DRAIN_CYCLES);
	endtask

	initial
	begin
		logic [23:0] dbg;
		logic [2:0]  st;
		void'($urandom(32'hb5bc));
		rst = 1'b1;
		afi_rdata_en = 1'b0;
		read_latency = rd_lat_t'(MIN_READ_LATENCY);
		mem_rdata_valid = 1'b0;
		mem_rdata = '0;
		pll_locked = 1'b0;
		afi_cal_success = 1'b0;
		afi_cal_fail = 1'b0;
		afi_cal_debug_info = '0;
		csr_addr = CSR_ADDR_STATUS;
		csr_read_req = 1'b0;
		csr_write_req = 1'b0;
		csr_wdata = '0;
		edge_n = 0;
		lat = MIN_READ_LATENCY;
		dly = 0;
		valid_count = 0;

		repeat (2)
			@(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		rst = 1'b0;

		// State right after reset
		check("afi_rdata_valid", 32'(afi_rdata_valid), 32'd0);
		check("csr_rdata_valid", 32'(csr_rdata_valid), 32'd0);
		expect_csr(CSR_ADDR_READ_COUNT, 32'd0, "csr_rdata READ_COUNT");
		expect_csr(CSR_ADDR_ERRORS, 32'd0, "csr_rdata ERRORS");

		for (int p = 0; p < NUM_PHASES; p++)
			run_phase(1'b0);

		// Consecutive enables keep many reads in flight
		run_phase(1'b1);

		// Missing memory word gives underflow
		lat = 2 + int'($urandom % 30);
		read_latency = rd_lat_t'(lat);
		tick(1'b1, 1'b1);
		idle(DRAIN_CYCLES);
		expect_csr(CSR_ADDR_ERRORS, 32'd2, "csr_rdata ERRORS");

		// Seventeen pushes with no pops overrun the FIFO
		for (int i = 0; i < 17; i++)
			push_due[edge_n + i] = 1'b1;
		idle(19);
		expect_csr(CSR_ADDR_ERRORS, 32'd3, "csr_rdata ERRORS");
		csr_write(CSR_ADDR_ERRORS, 32'd3);
		expect_csr(CSR_ADDR_ERRORS, 32'd0, "csr_rdata ERRORS");

		expect_csr(CSR_ADDR_READ_COUNT, csr_data_t'(valid_count % 65536),
			"csr_rdata READ_COUNT");

		repeat (4)
		begin
			st = 3'($urandom);
			dbg = 24'($urandom);
			pll_locked = st[0];
			afi_cal_success = st[1];
			afi_cal_fail = st[2];
			afi_cal_debug_info = dbg;
			expect_csr(CSR_ADDR_STATUS, {29'd0, st}, "csr_rdata STATUS");
			expect_csr(CSR_ADDR_DEBUG, {8'd0, dbg}, "csr_rdata DEBUG");
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
memphy_pkg.sv
read_valid_predictor.sv
read_data_fifo.sv
read_data_aligner.sv
phy_status_csr.sv
memphy_read_top.sv
tb_memphy.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator and run; exit status follows the testbench
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_memphy -f sources.f -o tb_memphy &&
./obj_dir/tb_memphy || exit 1
